//--- dmi_jtag_pkg.sv
package dmi_jtag_pkg;

   // tck half-period is tick_delay+1 clocks
   localparam int tick_delay = 2;

   // instruction register
   localparam int         ir_len   = 5;
   localparam logic [4:0] ir_dtmcs = 5'h10;
   localparam logic [4:0] ir_dmi   = 5'h11;

   // data registers
   localparam int dtmcs_len   = 32;
   localparam int dmi_len     = 41;
   localparam int dmi_abits   = 7;
   localparam int dmi_data_w  = 32;
   localparam int dmistat_lsb = 10;

   // init walk, counted in tck cycles
   localparam int reset_tcks = 10;
   localparam int idle_tcks  = 1;

   // dmi op and response codes
   localparam logic [1:0] op_nop   = 2'd0;
   localparam logic [1:0] op_read  = 2'd1;
   localparam logic [1:0] op_write = 2'd2;
   localparam logic [1:0] resp_ok  = 2'd0;
   localparam logic [1:0] resp_err = 2'd2;

   // tap states, pause and exit2 left out
   localparam logic [3:0] tap_reset    = 4'd0;
   localparam logic [3:0] tap_idle     = 4'd1;
   localparam logic [3:0] tap_sel_dr   = 4'd2;
   localparam logic [3:0] tap_cap_dr   = 4'd3;
   localparam logic [3:0] tap_shift_dr = 4'd4;
   localparam logic [3:0] tap_exit1_dr = 4'd5;
   localparam logic [3:0] tap_upd_dr   = 4'd6;
   localparam logic [3:0] tap_sel_ir   = 4'd7;
   localparam logic [3:0] tap_cap_ir   = 4'd8;
   localparam logic [3:0] tap_shift_ir = 4'd9;
   localparam logic [3:0] tap_exit1_ir = 4'd10;
   localparam logic [3:0] tap_upd_ir   = 4'd11;

   // request sequencer states
   localparam logic [2:0] seq_init  = 3'd0;
   localparam logic [2:0] seq_idle  = 3'd1;
   localparam logic [2:0] seq_poll1 = 3'd2;
   localparam logic [2:0] seq_write = 3'd3;
   localparam logic [2:0] seq_poll2 = 3'd4;
   localparam logic [2:0] seq_read  = 3'd5;
   localparam logic [2:0] seq_resp  = 3'd6;

   // one 41-bit dmi word, seen as request going in or response coming out
   typedef union packed {
      struct packed {
         logic [dmi_abits-1:0]  addr;
         logic [dmi_data_w-1:0] data;
         logic [1:0]            op;
      } req;
      struct packed {
         logic [dmi_abits-1:0]  addr;
         logic [dmi_data_w-1:0] data;
         logic [1:0]            resp;
      } rsp;
   } dmi_word_u;

endpackage

//--- jtag_scan_if.sv
`timescale 1ns/1ps

// one scan command from sequencer to tap driver, and its result
interface jtag_scan_if;
   logic                             start;
   logic                             ir_sel;
   logic [dmi_jtag_pkg::dmi_len-1:0] wdata;
   logic                             done;
   // right-aligned, valid while done is high
   logic [dmi_jtag_pkg::dmi_len-1:0] rdata;

   modport seq_mp (
      output start,
      output ir_sel,
      output wdata,
      input  done,
      input  rdata
   );

   modport tap_mp (
      input  start,
      input  ir_sel,
      input  wdata,
      output done,
      output rdata
   );
endinterface

//--- jtag_tap_driver.sv
`timescale 1ns/1ps

module jtag_tap_driver (
   input  logic        clock,
   input  logic        arst_n,
   input  logic        enable,
   jtag_scan_if.tap_mp scan,
   output logic        jtag_tck,
   output logic        jtag_tms,
   output logic        jtag_tdi,
   input  logic        jtag_tdo
);

   logic [7:0]                       tick_cnt;
   logic                             tick;
   logic                             tck_rise;
   logic                             tck_fall;
   logic [3:0]                       tap_state;
   logic [3:0]                       tap_nxt;
   logic [5:0]                       bit_cnt;
   logic [5:0]                       dr_last;
   logic                             init_run;
   logic                             scan_open;
   logic                             dr_leg;
   logic                             ir_sel_q;
   logic                             done_q;
   logic                             tms_nxt;
   logic                             tdi_nxt;
   logic [dmi_jtag_pkg::ir_len-1:0]  ir_sh;
   logic [dmi_jtag_pkg::dmi_len-1:0] dr_sh;

   // tap state after one tck rise; exit1 always leaves with tms high
   function automatic logic [3:0] tap_step(input logic [3:0] st, input logic tms);
      logic [3:0] nxt;
      case (st)
         dmi_jtag_pkg::tap_reset:
            nxt = tms ? dmi_jtag_pkg::tap_reset : dmi_jtag_pkg::tap_idle;
         dmi_jtag_pkg::tap_idle:
            nxt = tms ? dmi_jtag_pkg::tap_sel_dr : dmi_jtag_pkg::tap_idle;
         dmi_jtag_pkg::tap_sel_dr:
            nxt = tms ? dmi_jtag_pkg::tap_sel_ir : dmi_jtag_pkg::tap_cap_dr;
         dmi_jtag_pkg::tap_cap_dr:
            nxt = tms ? dmi_jtag_pkg::tap_exit1_dr : dmi_jtag_pkg::tap_shift_dr;
         dmi_jtag_pkg::tap_shift_dr:
            nxt = tms ? dmi_jtag_pkg::tap_exit1_dr : dmi_jtag_pkg::tap_shift_dr;
         dmi_jtag_pkg::tap_exit1_dr:
            nxt = dmi_jtag_pkg::tap_upd_dr;
         dmi_jtag_pkg::tap_upd_dr:
            nxt = tms ? dmi_jtag_pkg::tap_sel_dr : dmi_jtag_pkg::tap_idle;
         dmi_jtag_pkg::tap_sel_ir:
            nxt = tms ? dmi_jtag_pkg::tap_reset : dmi_jtag_pkg::tap_cap_ir;
         dmi_jtag_pkg::tap_cap_ir:
            nxt = tms ? dmi_jtag_pkg::tap_exit1_ir : dmi_jtag_pkg::tap_shift_ir;
         dmi_jtag_pkg::tap_shift_ir:
            nxt = tms ? dmi_jtag_pkg::tap_exit1_ir : dmi_jtag_pkg::tap_shift_ir;
         dmi_jtag_pkg::tap_exit1_ir:
            nxt = dmi_jtag_pkg::tap_upd_ir;
         dmi_jtag_pkg::tap_upd_ir:
            nxt = tms ? dmi_jtag_pkg::tap_sel_dr : dmi_jtag_pkg::tap_idle;
         default:
            nxt = dmi_jtag_pkg::tap_reset;
      endcase
      return nxt;
   endfunction

   assign tick     = enable && (tick_cnt == '0);
   assign tck_rise = tick && !jtag_tck;
   assign tck_fall = tick && jtag_tck;
   assign tap_nxt  = tap_step(tap_state, jtag_tms);
   assign dr_last  = ir_sel_q ? 6'(dmi_jtag_pkg::dmi_len - 1)
                              : 6'(dmi_jtag_pkg::dtmcs_len - 1);

   assign scan.done  = done_q;
   assign scan.rdata = dr_sh;

   // pin values for the next rise, set up on the fall
   always_comb begin
      tms_nxt = 1'b1;
      tdi_nxt = 1'b0;
      case (tap_state)
         dmi_jtag_pkg::tap_reset:  tms_nxt = (bit_cnt < 6'(dmi_jtag_pkg::reset_tcks));
         // one idle tck before leaving
         dmi_jtag_pkg::tap_idle:   tms_nxt = scan_open && (bit_cnt != '0);
         dmi_jtag_pkg::tap_sel_dr: tms_nxt = !dr_leg;
         dmi_jtag_pkg::tap_sel_ir: tms_nxt = 1'b0;
         dmi_jtag_pkg::tap_cap_ir: begin
            tms_nxt = 1'b0;
            tdi_nxt = ir_sh[0];
         end
         dmi_jtag_pkg::tap_shift_ir: begin
            tms_nxt = (bit_cnt == 6'(dmi_jtag_pkg::ir_len - 1));
            tdi_nxt = ir_sh[0];
         end
         dmi_jtag_pkg::tap_cap_dr: begin
            tms_nxt = 1'b0;
            tdi_nxt = dr_sh[0];
         end
         dmi_jtag_pkg::tap_shift_dr: begin
            tms_nxt = (bit_cnt == dr_last);
            tdi_nxt = dr_sh[0];
         end
         dmi_jtag_pkg::tap_upd_dr: tms_nxt = 1'b0;
         // exit1 and update-ir move on with tms high
         default:                  tms_nxt = 1'b1;
      endcase
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         tick_cnt  <= 8'(dmi_jtag_pkg::tick_delay);
         jtag_tck  <= 1'b0;
         jtag_tms  <= 1'b1;
         jtag_tdi  <= 1'b0;
         tap_state <= dmi_jtag_pkg::tap_reset;
         bit_cnt   <= '0;
         init_run  <= 1'b1;
         scan_open <= 1'b0;
         dr_leg    <= 1'b0;
         ir_sel_q  <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (enable) begin
            tick_cnt <= tick ? 8'(dmi_jtag_pkg::tick_delay) : tick_cnt - 8'd1;
         end
         if (tick) begin
            jtag_tck <= !jtag_tck;
         end
         if (tck_fall) begin
            jtag_tms <= tms_nxt;
            jtag_tdi <= tdi_nxt;
         end
         if (tck_rise) begin
            tap_state <= tap_nxt;
            if (init_run) begin
               // reset walk counts every rise
               if (bit_cnt == 6'(dmi_jtag_pkg::reset_tcks + dmi_jtag_pkg::idle_tcks - 1)) begin
                  init_run <= 1'b0;
                  bit_cnt  <= '0;
                  done_q   <= 1'b1;
               end else begin
                  bit_cnt <= bit_cnt + 6'd1;
               end
            end else if (tap_nxt != tap_state) begin
               bit_cnt <= '0;
            end else if (scan_open) begin
               bit_cnt <= bit_cnt + 6'd1;
            end
            if (tap_state == dmi_jtag_pkg::tap_upd_ir) begin
               dr_leg <= 1'b1;
            end
            if (tap_state == dmi_jtag_pkg::tap_upd_dr) begin
               scan_open <= 1'b0;
               done_q    <= 1'b1;
            end
         end
         if (scan.start) begin
            scan_open <= 1'b1;
            dr_leg    <= 1'b0;
            ir_sel_q  <= scan.ir_sel;
         end
      end
   end

   // shift registers, lsb goes out first and tdo enters at the top of the dr
   always_ff @(posedge clock) begin
      if (scan.start) begin
         ir_sh <= scan.ir_sel ? dmi_jtag_pkg::ir_dmi : dmi_jtag_pkg::ir_dtmcs;
         dr_sh <= scan.ir_sel ? scan.wdata
                              : {{(dmi_jtag_pkg::dmi_len - dmi_jtag_pkg::dtmcs_len){1'b0}},
                                 scan.wdata[dmi_jtag_pkg::dtmcs_len-1:0]};
      end else if (tck_rise) begin
         if (tap_state == dmi_jtag_pkg::tap_shift_ir) begin
            ir_sh <= ir_sh >> 1;
         end
         if (tap_state == dmi_jtag_pkg::tap_shift_dr) begin
            dr_sh <= ir_sel_q ? {jtag_tdo, dr_sh[dmi_jtag_pkg::dmi_len-1:1]}
                              : {{(dmi_jtag_pkg::dmi_len - dmi_jtag_pkg::dtmcs_len){1'b0}},
                                 jtag_tdo, dr_sh[dmi_jtag_pkg::dtmcs_len-1:1]};
         end
      end
   end

endmodule

//--- dmi_sequencer.sv
`timescale 1ns/1ps

module dmi_sequencer (
   input  logic                                  clock,
   input  logic                                  arst_n,
   input  logic                                  req_valid,
   input  logic [1:0]                            req_op,
   input  logic [dmi_jtag_pkg::dmi_abits-1:0]    req_addr,
   input  logic [dmi_jtag_pkg::dmi_data_w-1:0]   req_data,
   output logic                                  busy,
   output logic                                  resp_valid,
   output logic [1:0]                            resp_status,
   output logic [dmi_jtag_pkg::dmi_data_w-1:0]   resp_data,
   jtag_scan_if.seq_mp                           scan
);

   logic [2:0]              state;
   logic                    accept;
   logic                    stat_free;
   dmi_jtag_pkg::dmi_word_u req_q;
   dmi_jtag_pkg::dmi_word_u rsp_q;
   dmi_jtag_pkg::dmi_word_u nop_word;

   assign accept    = (state == dmi_jtag_pkg::seq_idle) && req_valid;
   assign stat_free = (scan.rdata[dmi_jtag_pkg::dmistat_lsb +: 2] == 2'b00);

   // polls and the result scan carry a nop
   always_comb begin
      nop_word.req.addr = '0;
      nop_word.req.data = '0;
      nop_word.req.op   = dmi_jtag_pkg::op_nop;
   end

   // start is registered, so state already names the scan it opens
   assign scan.wdata = (state == dmi_jtag_pkg::seq_write) ? req_q : nop_word;

   assign resp_status = rsp_q.rsp.resp;
   assign resp_data   = rsp_q.rsp.data;

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         state       <= dmi_jtag_pkg::seq_init;
         busy        <= 1'b1;
         resp_valid  <= 1'b0;
         scan.start  <= 1'b0;
         scan.ir_sel <= 1'b0;
      end else begin
         scan.start <= 1'b0;
         resp_valid <= 1'b0;
         case (state)
            dmi_jtag_pkg::seq_init: begin
               // done without start marks the end of the reset walk
               if (scan.done) begin
                  busy  <= 1'b0;
                  state <= dmi_jtag_pkg::seq_idle;
               end
            end
            dmi_jtag_pkg::seq_idle: begin
               if (req_valid) begin
                  busy        <= 1'b1;
                  scan.start  <= 1'b1;
                  scan.ir_sel <= 1'b0;
                  state       <= dmi_jtag_pkg::seq_poll1;
               end
            end
            dmi_jtag_pkg::seq_poll1: begin
               if (scan.done) begin
                  scan.start <= 1'b1;
                  if (stat_free) begin
                     scan.ir_sel <= 1'b1;
                     state       <= dmi_jtag_pkg::seq_write;
                  end
               end
            end
            dmi_jtag_pkg::seq_write: begin
               if (scan.done) begin
                  scan.start  <= 1'b1;
                  scan.ir_sel <= 1'b0;
                  state       <= dmi_jtag_pkg::seq_poll2;
               end
            end
            dmi_jtag_pkg::seq_poll2: begin
               if (scan.done) begin
                  scan.start <= 1'b1;
                  if (stat_free) begin
                     scan.ir_sel <= 1'b1;
                     state       <= dmi_jtag_pkg::seq_read;
                  end
               end
            end
            dmi_jtag_pkg::seq_read: begin
               if (scan.done) begin
                  state <= dmi_jtag_pkg::seq_resp;
               end
            end
            dmi_jtag_pkg::seq_resp: begin
               resp_valid <= 1'b1;
               busy       <= 1'b0;
               state      <= dmi_jtag_pkg::seq_idle;
            end
            default: state <= dmi_jtag_pkg::seq_idle;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (accept) begin
         req_q.req.addr <= req_addr;
         req_q.req.data <= req_data;
         req_q.req.op   <= req_op;
      end
      if ((state == dmi_jtag_pkg::seq_read) && scan.done) begin
         rsp_q <= scan.rdata;
      end
   end

endmodule

//--- dmi_jtag_top.sv
`timescale 1ns/1ps

module dmi_jtag_top (
   input  logic                                  clock,
   input  logic                                  arst_n,
   input  logic                                  enable,
   input  logic                                  req_valid,
   input  logic [1:0]                            req_op,
   input  logic [dmi_jtag_pkg::dmi_abits-1:0]    req_addr,
   input  logic [dmi_jtag_pkg::dmi_data_w-1:0]   req_data,
   output logic                                  busy,
   output logic                                  resp_valid,
   output logic [1:0]                            resp_status,
   output logic [dmi_jtag_pkg::dmi_data_w-1:0]   resp_data,
   output logic                                  jtag_tck,
   output logic                                  jtag_tms,
   output logic                                  jtag_tdi,
   input  logic                                  jtag_tdo
);

   // scan commands between the two halves
   jtag_scan_if scan_bus ();

   dmi_sequencer u_seq (
      .clock       (clock),
      .arst_n      (arst_n),
      .req_valid   (req_valid),
      .req_op      (req_op),
      .req_addr    (req_addr),
      .req_data    (req_data),
      .busy        (busy),
      .resp_valid  (resp_valid),
      .resp_status (resp_status),
      .resp_data   (resp_data),
      .scan        (scan_bus.seq_mp)
   );

   jtag_tap_driver u_tap (
      .clock    (clock),
      .arst_n   (arst_n),
      .enable   (enable),
      .scan     (scan_bus.tap_mp),
      .jtag_tck (jtag_tck),
      .jtag_tms (jtag_tms),
      .jtag_tdi (jtag_tdi),
      .jtag_tdo (jtag_tdo)
   );

endmodule

//--- jtag_dtm_model.sv
`timescale 1ns/1ps

// behavioral debug transport module seen from the jtag pins
module jtag_dtm_model (
   input  logic       jtag_tck,
   input  logic       jtag_tms,
   input  logic       jtag_tdi,
   output logic       jtag_tdo,
   input  logic [1:0] busy_polls
);

   logic [3:0]              state     = dmi_jtag_pkg::tap_reset;
   logic [4:0]              ir        = 5'h01;
   logic                    tdo_q     = 1'b0;
   int                      busy_left = 0;
   logic [4:0]              ir_sr;
   logic [40:0]             dr_sr;
   logic [31:0]             mem [64];
   dmi_jtag_pkg::dmi_word_u result = '0;
   dmi_jtag_pkg::dmi_word_u cmd;

   assign jtag_tdo = tdo_q;

   // standard tap walk without the pause states
   function automatic logic [3:0] tap_next(input logic [3:0] st, input logic tms);
      case (st)
         dmi_jtag_pkg::tap_reset:
            return tms ? st : dmi_jtag_pkg::tap_idle;
         dmi_jtag_pkg::tap_idle:
            return tms ? dmi_jtag_pkg::tap_sel_dr : st;
         dmi_jtag_pkg::tap_sel_dr:
            return tms ? dmi_jtag_pkg::tap_sel_ir : dmi_jtag_pkg::tap_cap_dr;
         dmi_jtag_pkg::tap_sel_ir:
            return tms ? dmi_jtag_pkg::tap_reset : dmi_jtag_pkg::tap_cap_ir;
         dmi_jtag_pkg::tap_cap_dr,
         dmi_jtag_pkg::tap_shift_dr:
            return tms ? dmi_jtag_pkg::tap_exit1_dr : dmi_jtag_pkg::tap_shift_dr;
         dmi_jtag_pkg::tap_cap_ir,
         dmi_jtag_pkg::tap_shift_ir:
            return tms ? dmi_jtag_pkg::tap_exit1_ir : dmi_jtag_pkg::tap_shift_ir;
         dmi_jtag_pkg::tap_exit1_dr:
            return dmi_jtag_pkg::tap_upd_dr;
         dmi_jtag_pkg::tap_exit1_ir:
            return dmi_jtag_pkg::tap_upd_ir;
         dmi_jtag_pkg::tap_upd_dr,
         dmi_jtag_pkg::tap_upd_ir:
            return tms ? dmi_jtag_pkg::tap_sel_dr : dmi_jtag_pkg::tap_idle;
         default:
            return dmi_jtag_pkg::tap_reset;
      endcase
   endfunction

   initial begin
      for (int i = 0; i < 64; i++) begin
         mem[i] = 32'h9e37_79b9 * (i + 1);
      end
   end

   always @(posedge jtag_tck) begin
      case (state)
         dmi_jtag_pkg::tap_reset:    ir <= 5'h01;
         dmi_jtag_pkg::tap_cap_ir:   ir_sr <= 5'b00001;
         dmi_jtag_pkg::tap_shift_ir: ir_sr <= {jtag_tdi, ir_sr[4:1]};
         dmi_jtag_pkg::tap_upd_ir:   ir <= ir_sr;
         dmi_jtag_pkg::tap_cap_dr: begin
            if (ir == dmi_jtag_pkg::ir_dtmcs) begin
               // dmistat 3 while the last request is still busy, abits 7, version 1
               dr_sr <= {9'd0, 20'd0, (busy_left > 0) ? 2'b11 : 2'b00, 6'd7, 4'd1};
               if (busy_left > 0) begin
                  busy_left <= busy_left - 1;
               end
            end else if (ir == dmi_jtag_pkg::ir_dmi) begin
               // a dmi access before dmistat clears only sees the busy code
               dr_sr <= (busy_left > 0) ? {39'd0, 2'b11} : result;
            end else begin
               dr_sr <= '0;
            end
         end
         dmi_jtag_pkg::tap_shift_dr: begin
            if (ir == dmi_jtag_pkg::ir_dmi) begin
               dr_sr <= {jtag_tdi, dr_sr[40:1]};
            end else if (ir == dmi_jtag_pkg::ir_dtmcs) begin
               dr_sr <= {9'd0, jtag_tdi, dr_sr[31:1]};
            end else begin
               dr_sr <= {40'd0, jtag_tdi};
            end
         end
         dmi_jtag_pkg::tap_upd_dr: begin
            cmd = dr_sr;
            // dtmcs writes are ignored and a nop leaves the last result in place
            if (ir == dmi_jtag_pkg::ir_dmi && cmd.req.op != dmi_jtag_pkg::op_nop) begin
               busy_left        <= busy_polls;
               result.rsp.addr  <= cmd.req.addr;
               result.rsp.data  <= '0;
               result.rsp.resp  <= dmi_jtag_pkg::resp_ok;
               if (cmd.req.addr >= 7'd64) begin
                  result.rsp.resp <= dmi_jtag_pkg::resp_err;
               end else if (cmd.req.op == dmi_jtag_pkg::op_write) begin
                  mem[cmd.req.addr[5:0]] <= cmd.req.data;
               end else if (cmd.req.op == dmi_jtag_pkg::op_read) begin
                  result.rsp.data <= mem[cmd.req.addr[5:0]];
               end
            end
         end
         default: ;
      endcase
      state <= tap_next(state, jtag_tms);
   end

   // tdo moves on the falling edge
   always @(negedge jtag_tck) begin
      if (state == dmi_jtag_pkg::tap_shift_dr) begin
         tdo_q <= dr_sr[0];
      end else if (state == dmi_jtag_pkg::tap_shift_ir) begin
         tdo_q <= ir_sr[0];
      end else begin
         tdo_q <= 1'b0;
      end
   end

endmodule

//--- dmi_jtag_monitor.sv
`timescale 1ns/1ps

module dmi_jtag_monitor (
   input  logic        clock,
   input  logic        arst_n,
   input  logic        req_valid,
   input  logic        busy,
   input  logic        resp_valid,
   input  logic [1:0]  resp_status,
   input  logic [31:0] resp_data,
   input  logic        jtag_tck,
   input  logic        jtag_tms,
   input  logic        jtag_tdi,
   input  logic [1:0]  exp_status,
   input  logic [31:0] exp_data,
   output int          errors,
   output int          checks,
   output int          accepts,
   output int          responses
);

   localparam int init_rises = dmi_jtag_pkg::reset_tcks + dmi_jtag_pkg::idle_tcks;

   int   tck_rises;
   logic primed;
   logic accept_q;
   logic tck_q;
   logic tms_q;
   logic tdi_q;

   initial begin
      errors    = 0;
      checks    = 0;
      accepts   = 0;
      responses = 0;
      tck_rises = 0;
      primed    = 1'b0;
      accept_q  = 1'b0;
   end

   always @(posedge clock) begin
      if (arst_n && primed) begin
         // reset walk: tms high for the reset tcks, then low for idle
         if (jtag_tck && !tck_q) begin
            tck_rises++;
            if (tck_rises <= init_rises) begin
               checks++;
               if (jtag_tms !== (tck_rises <= dmi_jtag_pkg::reset_tcks)) begin
                  errors++;
                  $display("Fail at %0t: tms is %b on init tck rise %0d",
                           $time, jtag_tms, tck_rises);
               end
            end
         end
         if (!busy && tck_rises < init_rises) begin
            errors++;
            $display("busy went low at %0t before the reset walk was over", $time);
         end
         if ((jtag_tms !== tms_q || jtag_tdi !== tdi_q) && !(tck_q && !jtag_tck)) begin
            errors++;
            $display("Fail at %0t: tms or tdi changed outside a tck fall", $time);
         end
         if (accept_q) begin
            checks++;
            if (busy !== 1'b1) begin
               errors++;
               $display("Fail at %0t: busy still low the cycle after acceptance", $time);
            end
         end
         accept_q = req_valid && !busy;
         if (accept_q) begin
            accepts++;
         end
         if (resp_valid) begin
            responses++;
            checks++;
            if (responses > accepts) begin
               errors++;
               $display("a response came at %0t with no accepted request left", $time);
            end
            if (resp_status !== exp_status || resp_data !== exp_data) begin
               errors++;
               $display("Fail at %0t: response %0d/%h, expected %0d/%h",
                        $time, resp_status, resp_data, exp_status, exp_data);
            end
         end
      end
      primed = 1'b1;
      tck_q  = jtag_tck;
      tms_q  = jtag_tms;
      tdi_q  = jtag_tdi;
   end

endmodule

//--- dmi_jtag_checker.sv
`timescale 1ns/1ps

module dmi_jtag_checker (
   input logic clock,
   input logic arst_n,
   input logic enable,
   input logic busy,
   input logic resp_valid,
   input logic jtag_tck
);

   int unsigned assert_errors = 0;

   // divider frozen while enable is low
   tck_frozen: assert property (@(posedge clock) disable iff (!arst_n)
      !enable |=> $stable(jtag_tck))
      else begin
         assert_errors++;
         $error("jtag_tck changed while enable was low");
      end

   no_resp_when_disabled: assert property (@(posedge clock) disable iff (!arst_n)
      !enable |-> !resp_valid)
      else begin
         assert_errors++;
         $error("resp_valid high while enable was low");
      end

   resp_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
      resp_valid |=> !resp_valid)
      else begin
         assert_errors++;
         $error("resp_valid lasted more than one cycle");
      end

   resp_after_busy: assert property (@(posedge clock) disable iff (!arst_n)
      resp_valid |-> $past(busy))
      else begin
         assert_errors++;
         $error("resp_valid without busy high in the cycle before");
      end

endmodule

//--- dmi_jtag_tb.sv
`timescale 1ns/1ps

module dmi_jtag_tb;

   localparam int clk_ns       = 100;
   localparam int num_rows     = 9;
   localparam int tck_ns       = 2 * (dmi_jtag_pkg::tick_delay + 1) * clk_ns;
   // six scans of up to 90 tck per row
   localparam int run_limit_ns = num_rows * 6 * 90 * tck_ns;

   typedef struct packed {
      logic [1:0]  op;
      logic [6:0]  addr;
      logic [31:0] data;
      logic [1:0]  polls;
      logic [1:0]  status;
      logic [31:0] rdata;
   } row_t;

   // op, address, data, busy polls, expected status, expected data
   localparam row_t rows [num_rows] = '{
      '{dmi_jtag_pkg::op_write, 7'h05, 32'hdead_beef, 2'd0, dmi_jtag_pkg::resp_ok,  32'h0},
      '{dmi_jtag_pkg::op_read,  7'h05, 32'h0,         2'd0, dmi_jtag_pkg::resp_ok,  32'hdead_beef},
      '{dmi_jtag_pkg::op_write, 7'h3f, 32'h1234_5678, 2'd1, dmi_jtag_pkg::resp_ok,  32'h0},
      '{dmi_jtag_pkg::op_read,  7'h3f, 32'h0,         2'd1, dmi_jtag_pkg::resp_ok,  32'h1234_5678},
      '{dmi_jtag_pkg::op_write, 7'h20, 32'ha5a5_0f0f, 2'd3, dmi_jtag_pkg::resp_ok,  32'h0},
      '{dmi_jtag_pkg::op_read,  7'h20, 32'h0,         2'd3, dmi_jtag_pkg::resp_ok,  32'ha5a5_0f0f},
      '{dmi_jtag_pkg::op_write, 7'h40, 32'hffff_ffff, 2'd1, dmi_jtag_pkg::resp_err, 32'h0},
      '{dmi_jtag_pkg::op_read,  7'h7f, 32'h0,         2'd0, dmi_jtag_pkg::resp_err, 32'h0},
      '{dmi_jtag_pkg::op_read,  7'h05, 32'h0,         2'd3, dmi_jtag_pkg::resp_ok,  32'hdead_beef}
   };

   logic        clock;
   logic        arst_n;
   logic        enable;
   logic        req_valid;
   logic [1:0]  req_op;
   logic [6:0]  req_addr;
   logic [31:0] req_data;
   logic        busy;
   logic        resp_valid;
   logic [1:0]  resp_status;
   logic [31:0] resp_data;
   logic        jtag_tck;
   logic        jtag_tms;
   logic        jtag_tdi;
   logic        jtag_tdo;
   logic [1:0]  busy_polls;
   logic [1:0]  exp_status;
   logic [31:0] exp_data;
   int          errors;
   int          checks;
   int          accepts;
   int          responses;
   int          count_errors;

   dmi_jtag_top UUT (
      .clock       (clock),
      .arst_n      (arst_n),
      .enable      (enable),
      .req_valid   (req_valid),
      .req_op      (req_op),
      .req_addr    (req_addr),
      .req_data    (req_data),
      .busy        (busy),
      .resp_valid  (resp_valid),
      .resp_status (resp_status),
      .resp_data   (resp_data),
      .jtag_tck    (jtag_tck),
      .jtag_tms    (jtag_tms),
      .jtag_tdi    (jtag_tdi),
      .jtag_tdo    (jtag_tdo)
   );

   jtag_dtm_model u_dtm (
      .jtag_tck   (jtag_tck),
      .jtag_tms   (jtag_tms),
      .jtag_tdi   (jtag_tdi),
      .jtag_tdo   (jtag_tdo),
      .busy_polls (busy_polls)
   );

   dmi_jtag_monitor u_mon (
      .clock       (clock),
      .arst_n      (arst_n),
      .req_valid   (req_valid),
      .busy        (busy),
      .resp_valid  (resp_valid),
      .resp_status (resp_status),
      .resp_data   (resp_data),
      .jtag_tck    (jtag_tck),
      .jtag_tms    (jtag_tms),
      .jtag_tdi    (jtag_tdi),
      .exp_status  (exp_status),
      .exp_data    (exp_data),
      .errors      (errors),
      .checks      (checks),
      .accepts     (accepts),
      .responses   (responses)
   );

   bind dmi_jtag_top dmi_jtag_checker u_checker (
      .clock      (clock),
      .arst_n     (arst_n),
      .enable     (enable),
      .busy       (busy),
      .resp_valid (resp_valid),
      .jtag_tck   (jtag_tck)
   );

   initial begin
      clock = 1'b0;
      forever #(clk_ns / 2) clock = ~clock;
   end

   task automatic wait_until_idle();
      do @(posedge clock); while (busy);
   endtask

   task automatic send_request(input row_t r);
      busy_polls <= r.polls;
      exp_status <= r.status;
      exp_data   <= r.rdata;
      req_op     <= r.op;
      req_addr   <= r.addr;
      req_data   <= r.data;
      req_valid  <= 1'b1;
      @(posedge clock);
      req_valid  <= 1'b0;
   endtask

   // a request that arrives while busy must be dropped
   task automatic pulse_while_busy(input row_t r);
      repeat (3) @(posedge clock);
      req_op    <= dmi_jtag_pkg::op_write;
      req_addr  <= r.addr ^ 7'h01;
      req_data  <= ~r.data;
      req_valid <= 1'b1;
      @(posedge clock);
      req_valid <= 1'b0;
   endtask

   task automatic stall_enable(input int cycles);
      enable <= 1'b0;
      repeat (cycles) @(posedge clock);
      enable <= 1'b1;
   endtask

   task automatic wait_for_response();
      do @(posedge clock); while (!resp_valid);
   endtask

   initial begin
      int unsigned seed_ret;
      int          gap;
      seed_ret     = $urandom(32'ha76b);
      count_errors = 0;
      arst_n       = 1'b0;
      enable       = 1'b1;
      req_valid    = 1'b0;
      req_op       = '0;
      req_addr     = '0;
      req_data     = '0;
      busy_polls   = '0;
      exp_status   = '0;
      exp_data     = '0;
      repeat (2) @(posedge clock);
      arst_n <= 1'b1;
      for (int i = 0; i < num_rows; i++) begin
         gap = $urandom_range(1, 6);
         repeat (gap) @(posedge clock);
         wait_until_idle();
         send_request(rows[i]);
         pulse_while_busy(rows[i]);
         stall_enable($urandom_range(4, 20));
         wait_for_response();
      end
      repeat (20) @(posedge clock);
      if (responses != num_rows || accepts != num_rows) begin
         count_errors++;
         $display("saw %0d accepts and %0d responses for %0d requests",
                  accepts, responses, num_rows);
      end
      $display("checks %0d, monitor errors %0d, count errors %0d, assertion errors %0d",
               checks, errors, count_errors, UUT.u_checker.assert_errors);
      if (errors == 0 && count_errors == 0 && UUT.u_checker.assert_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(run_limit_ns);
      $display("timeout after %0d ns while waiting for the DUT", run_limit_ns);
      $display("Test failed");
      $finish;
   end

endmodule

//--- all.f
dmi_jtag_pkg.sv
jtag_scan_if.sv
jtag_tap_driver.sv
dmi_sequencer.sv
dmi_jtag_top.sv
jtag_dtm_model.sv
dmi_jtag_monitor.sv
dmi_jtag_checker.sv
dmi_jtag_tb.sv
